// File: dv/host_ctrl_tb.sv
`default_nettype none

module host_ctrl_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import host_pkg::*;

  localparam int RESET_TIMEOUT = 20;
  localparam int CLK_NS = 40;
  // Watchdog allows twice the rough cycle budget of all tests.
  localparam int TEST_CYCLES = 16 + 10 + 50 + 4 * 40 + 40 + (3 * RESET_TIMEOUT + 60) + 40;
  localparam int WATCHDOG_NS = 2 * TEST_CYCLES * CLK_NS;

  logic        user_clk = 1'b0;
  logic        rst_n;
  axil_req_t   req;
  axil_rsp_t   rsp;
  state_port_t st_in;
  cmd_port_t   cmd;
  logic        core_reset;

  int          cyc = 0;
  int          accept_cyc;
  int          test_errs = 0;
  int          err_total = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  logic [31:0] lfsr = 32'h48f2;
  int          pulse_cyc[$];
  cmd_port_t   pulse_q[$];

  host_ctrl_top #(
    .RESET_TIMEOUT (RESET_TIMEOUT)
  ) u_dut (
    .user_clk     (user_clk),
    .rst_n_i      (rst_n),
    .axil_req_i   (req),
    .axil_rsp_o   (rsp),
    .state_i      (st_in),
    .cmd_o        (cmd),
    .core_reset_o (core_reset)
  );

  always #(CLK_NS / 2) user_clk = ~user_clk;

  always @(posedge user_clk) cyc <= cyc + 1;

  // Command pulses with the edge count they followed.
  always @(negedge user_clk) begin
    if (cmd.valid) begin
      pulse_cyc.push_back(cyc);
      pulse_q.push_back(cmd);
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired, the tests did not finish in time");
    $display("Verification failed");
    $finish;
  end

  // Fibonacci LFSR with taps 32 22 2 1.
  function automatic logic [31:0] rand_word(input int nbits);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < nbits; i++) begin
      fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v = {v[30:0], fb};
    end
    return v;
  endfunction

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("** Error: %s is %h, expected %h at %0t", name, got, exp, $time);
      test_errs++;
    end
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (test_errs == 0) begin
      $display("PASS %s", name);
    end else begin
      $display("FAIL %s with %0d errors", name, test_errs);
      tests_failed++;
    end
    err_total += test_errs;
    test_errs = 0;
  endtask

  task automatic bus_write(input int idx, input logic [31:0] data, input logic [3:0] strb,
                           input int hold);
    @(posedge user_clk);
    #2;
    req.awaddr  = idx * 4;
    req.awvalid = 1'b1;
    req.wdata   = data;
    req.wstrb   = strb;
    req.wvalid  = 1'b1;
    @(negedge user_clk);
    while (!rsp.awready) @(negedge user_clk);
    check_word("wready", 32'(rsp.wready), 32'h1);
    accept_cyc = cyc + 1;
    @(posedge user_clk);
    #2;
    req.awvalid = (hold > 0);
    req.wvalid  = (hold > 0);
    for (int i = 0; i < hold; i++) begin
      @(negedge user_clk);
      if (!rsp.bvalid || rsp.awready || rsp.wready) begin
        $display("Write response lost or a second write accepted while bready was low");
        test_errs++;
      end
      check_word("bresp", 32'(rsp.bresp), 32'h0);
    end
    if (hold > 0) begin
      @(posedge user_clk);
      #2;
    end
    req.awvalid = 1'b0;
    req.wvalid  = 1'b0;
    req.bready  = 1'b1;
    @(negedge user_clk);
    if (!rsp.bvalid) begin
      $display("Write response missing at %0t", $time);
      test_errs++;
    end
    check_word("bresp", 32'(rsp.bresp), 32'h0);
    @(posedge user_clk);
    #2;
    req.bready = 1'b0;
  endtask

  task automatic bus_read(input int idx, input int hold, output logic [31:0] data);
    @(posedge user_clk);
    #2;
    req.araddr  = idx * 4;
    req.arvalid = 1'b1;
    @(negedge user_clk);
    while (!rsp.arready) @(negedge user_clk);
    @(posedge user_clk);
    #2;
    req.arvalid = (hold > 0);
    @(negedge user_clk);
    data = rsp.rdata;
    if (!rsp.rvalid) begin
      $display("Read response missing at %0t", $time);
      test_errs++;
    end
    check_word("rresp", 32'(rsp.rresp), 32'h0);
    for (int i = 0; i < hold; i++) begin
      @(negedge user_clk);
      if (!rsp.rvalid || rsp.arready || rsp.rdata !== data) begin
        $display("Read response changed or a second read accepted while rready was low");
        test_errs++;
      end
    end
    @(posedge user_clk);
    #2;
    req.arvalid = 1'b0;
    req.rready  = 1'b1;
    @(posedge user_clk);
    #2;
    req.rready = 1'b0;
  endtask

  task automatic reset_state_test();
    logic [31:0] d;
    if (rsp.awready || rsp.wready || rsp.bvalid || rsp.arready || rsp.rvalid ||
        cmd.valid || core_reset) begin
      $display("A ready, valid or reset output is high after reset");
      test_errs++;
    end
    bus_read(0, 0, d);
    check_word("rdata", d, 32'h0);
    end_test("reset_state");
  endtask

  task automatic status_readback_test();
    logic [31:0] sw[4];
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] d;
    for (int i = 0; i < 4; i++) begin
      sw[i] = rand_word(32);
    end
    @(posedge user_clk);
    #2;
    st_in = '{state0: sw[0], state1: sw[1], state2: sw[2], state3: sw[3]};
    for (int w = 1; w <= 4; w++) begin
      bus_read(w, 0, d);
      check_word("rdata", d, sw[w-1]);
    end
    for (int w = 5; w <= 7; w++) begin
      bus_read(w, 0, d);
      check_word("rdata", d, 32'h0);
    end
    a = rand_word(32);
    b = rand_word(32);
    bus_write(0, a, 4'hf, 0);
    bus_write(0, b, 4'b0101, 0);
    bus_read(0, 0, d);
    check_word("rdata", d, {a[31:24], b[23:16], a[15:8], b[7:0]});
    end_test("status_readback");
  endtask

  task automatic cmd_launch_test();
    logic [31:0] a1;
    logic [31:0] a2;
    logic [31:0] a3;
    int          d;
    for (int it = 0; it < 4; it++) begin
      d  = rand_word(4) % 11;
      a1 = rand_word(32);
      a2 = rand_word(32);
      a3 = rand_word(32);
      bus_write(ARG_CMD, a1, 4'hf, 0);
      bus_write(ARG_DATA0, a2, 4'hf, 0);
      bus_write(ARG_DATA1, a3, 4'hf, 0);
      bus_write(ARG_DELAY, d, 4'hf, 0);
      pulse_cyc.delete();
      pulse_q.delete();
      bus_write(REG_CMD, rand_word(8), 4'hf, 0);
      repeat (d + 6) @(negedge user_clk);
      if (pulse_q.size() != 1) begin
        $display("Expected one command pulse for delay %0d, saw %0d", d, pulse_q.size());
        test_errs++;
      end else begin
        check_word("cmd_o.valid edge", pulse_cyc[0] - accept_cyc, d + 2);
        check_word("cmd_o.command", 32'(pulse_q[0].command), 32'(a1[7:0]));
        check_word("cmd_o.data0", pulse_q[0].data0, a2);
        check_word("cmd_o.data1", pulse_q[0].data1, a3);
      end
    end
    end_test("cmd_launch");
  endtask

  task automatic cmd_restart_test();
    logic [31:0] a1;
    logic [31:0] a2;
    int          second;
    a1 = rand_word(32);
    a2 = rand_word(32);
    bus_write(ARG_CMD, a1, 4'hf, 0);
    bus_write(ARG_DELAY, 10, 4'hf, 0);
    pulse_cyc.delete();
    pulse_q.delete();
    bus_write(REG_CMD, 32'h1, 4'hf, 0);
    bus_write(ARG_DATA0, a2, 4'hf, 0);
    bus_write(REG_CMD, 32'h2, 4'hf, 0);
    second = accept_cyc;
    repeat (18) @(negedge user_clk);
    if (pulse_q.size() != 1) begin
      $display("Expected one command pulse after restart, saw %0d", pulse_q.size());
      test_errs++;
    end else begin
      check_word("cmd_o.valid edge", pulse_cyc[0] - second, 32'd12);
      check_word("cmd_o.command", 32'(pulse_q[0].command), 32'(a1[7:0]));
      check_word("cmd_o.data0", pulse_q[0].data0, a2);
    end
    end_test("cmd_restart");
  endtask

  task automatic reset_timer_test();
    int start;
    bus_write(REG_CTRL, 32'h1, 4'hf, 0);
    start = accept_cyc;
    @(negedge user_clk);
    while (!core_reset && cyc < start + RESET_TIMEOUT + 8) @(negedge user_clk);
    if (!core_reset) begin
      $display("Core reset did not rise after the timer was started");
      test_errs++;
    end else if (cyc - start < RESET_TIMEOUT) begin
      $display("** Error: core_reset_o rose %0h edges after start, expected at least %0h",
               cyc - start, RESET_TIMEOUT);
      test_errs++;
    end
    repeat (5) @(negedge user_clk);
    if (!core_reset) begin
      $display("Core reset level dropped without a clear");
      test_errs++;
    end
    bus_write(REG_CTRL, 32'h2, 4'hf, 0);
    @(negedge user_clk);
    if (core_reset) begin
      $display("Core reset still high after a clear write");
      test_errs++;
    end
    // Start and clear in two writes and then in one.
    bus_write(REG_CTRL, 32'h1, 4'hf, 0);
    bus_write(REG_CTRL, 32'h2, 4'hf, 0);
    bus_write(REG_CTRL, 32'h3, 4'hf, 0);
    for (int i = 0; i < RESET_TIMEOUT + 6; i++) begin
      @(negedge user_clk);
      if (core_reset) begin
        $display("Core reset rose although the timer was cleared");
        test_errs++;
      end
    end
    end_test("reset_timer");
  endtask

  task automatic back_pressure_test();
    logic [31:0] v;
    logic [31:0] d;
    v = rand_word(32);
    bus_write(0, v, 4'hf, 4);
    bus_read(0, 4, d);
    check_word("rdata", d, v);
    bus_read(2, 5, d);
    check_word("rdata", d, st_in.state1);
    end_test("back_pressure");
  endtask

  initial begin
    req   = '0;
    st_in = '0;
    rst_n = 1'b0;
    repeat (16) @(posedge user_clk);
    #2;
    rst_n = 1'b1;
    reset_state_test();
    status_readback_test();
    cmd_launch_test();
    cmd_restart_test();
    reset_timer_test();
    back_pressure_test();
    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, err_total);
    if (err_total == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing -Wno-fatal -f sim.f --top-module host_ctrl_tb \
    -Mdir obj_dir -o host_ctrl_sim; then
  echo "Build with Verilator failed"
  exit 1
fi

if ! ./obj_dir/host_ctrl_sim > "$LOG" 2>&1; then
  cat "$LOG"
  echo "Simulation exited with an error status"
  exit 1
fi

cat "$LOG"
if grep -q "^Verification passed$" "$LOG"; then
  exit 0
fi
exit 1

// File: sim.f
source/host_pkg.sv
source/host_reg_slave.sv
source/kernel_cmd_launcher.sv
source/core_reset_timer.sv
source/host_ctrl_top.sv
dv/host_ctrl_tb.sv

// File: source/core_reset_timer.sv
`default_nettype none

module core_reset_timer #(
  parameter int unsigned RESET_TIMEOUT = 64
) (
  input  logic user_clk,
  input  logic rst_n_i,
  input  logic timer_start_i,
  input  logic timer_clear_i,
  output logic core_reset_o
);

  localparam int CNT_W = $clog2(RESET_TIMEOUT + 1);

  logic             running_q;
  logic [CNT_W-1:0] count_q;

  always_ff @(posedge user_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      running_q    <= 1'b0;
      count_q      <= '0;
      core_reset_o <= 1'b0;
    end else if (timer_clear_i) begin
      // Clear has priority over start.
      running_q    <= 1'b0;
      count_q      <= '0;
      core_reset_o <= 1'b0;
    end else if (timer_start_i) begin
      running_q <= 1'b1;
      count_q   <= '0;
    end else if (running_q) begin
      if (count_q == CNT_W'(RESET_TIMEOUT)) begin
        // Timed out, hold the reset level.
        running_q    <= 1'b0;
        core_reset_o <= 1'b1;
      end else begin
        count_q <= count_q + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: source/host_ctrl_top.sv
`default_nettype none

module host_ctrl_top #(
  parameter int unsigned RESET_TIMEOUT = 64
) (
  input  logic                  user_clk,
  input  logic                  rst_n_i,
  input  host_pkg::axil_req_t   axil_req_i,
  output host_pkg::axil_rsp_t   axil_rsp_o,
  input  host_pkg::state_port_t state_i,
  output host_pkg::cmd_port_t   cmd_o,
  output logic                  core_reset_o
);
  import host_pkg::*;

  arg_bank_t args;
  logic      kernel_cmd_new;
  logic      timer_start;
  logic      timer_clear;

  // Kernel command byte has no consumer here.
  host_reg_slave u_reg_slave (
    .user_clk         (user_clk),
    .rst_n_i          (rst_n_i),
    .axil_req_i       (axil_req_i),
    .axil_rsp_o       (axil_rsp_o),
    .state_i          (state_i),
    .args_o           (args),
    .kernel_cmd_o     (),
    .kernel_cmd_new_o (kernel_cmd_new),
    .timer_start_o    (timer_start),
    .timer_clear_o    (timer_clear)
  );

  kernel_cmd_launcher u_cmd_launcher (
    .user_clk         (user_clk),
    .rst_n_i          (rst_n_i),
    .kernel_cmd_new_i (kernel_cmd_new),
    .args_i           (args),
    .cmd_o            (cmd_o)
  );

  core_reset_timer #(
    .RESET_TIMEOUT (RESET_TIMEOUT)
  ) u_reset_timer (
    .user_clk      (user_clk),
    .rst_n_i       (rst_n_i),
    .timer_start_i (timer_start),
    .timer_clear_i (timer_clear),
    .core_reset_o  (core_reset_o)
  );

endmodule

`default_nettype wire

// File: source/host_pkg.sv
`default_nettype none

package host_pkg;

  localparam int ADDR_W  = 32;
  localparam int DATA_W  = 32;
  localparam int STRB_W  = 4;
  localparam int ARG_NUM = 8;

  // Word indices in the register map.
  localparam int REG_CMD  = 8;
  localparam int REG_CTRL = 9;

  // Argument slots used by the command launcher.
  localparam int ARG_CMD   = 1;
  localparam int ARG_DATA0 = 2;
  localparam int ARG_DATA1 = 3;
  localparam int ARG_DELAY = 4;

  localparam logic [1:0] RESP_OKAY = 2'b00;

  typedef logic [ARG_NUM-1:0][DATA_W-1:0] arg_bank_t;

  typedef struct packed {
    logic [DATA_W-1:0] state0;
    logic [DATA_W-1:0] state1;
    logic [DATA_W-1:0] state2;
    logic [DATA_W-1:0] state3;
  } state_port_t;

  typedef struct packed {
    logic              valid;
    logic [7:0]        command;
    logic [DATA_W-1:0] data0;
    logic [DATA_W-1:0] data1;
  } cmd_port_t;

  typedef struct packed {
    logic [ADDR_W-1:0] awaddr;
    logic              awvalid;
    logic [DATA_W-1:0] wdata;
    logic [STRB_W-1:0] wstrb;
    logic              wvalid;
    logic              bready;
    logic [ADDR_W-1:0] araddr;
    logic              arvalid;
    logic              rready;
  } axil_req_t;

  typedef struct packed {
    logic              awready;
    logic              wready;
    logic [1:0]        bresp;
    logic              bvalid;
    logic              arready;
    logic [DATA_W-1:0] rdata;
    logic [1:0]        rresp;
    logic              rvalid;
  } axil_rsp_t;

endpackage

`default_nettype wire

// File: source/host_reg_slave.sv
`default_nettype none

module host_reg_slave (
  input  logic                  user_clk,
  input  logic                  rst_n_i,
  input  host_pkg::axil_req_t   axil_req_i,
  output host_pkg::axil_rsp_t   axil_rsp_o,
  input  host_pkg::state_port_t state_i,
  output host_pkg::arg_bank_t   args_o,
  output logic [7:0]            kernel_cmd_o,
  output logic                  kernel_cmd_new_o,
  output logic                  timer_start_o,
  output logic                  timer_clear_o
);
  import host_pkg::*;

  logic              wr_fire;
  logic              rd_fire;
  logic [3:0]        wr_idx;
  logic [3:0]        rd_idx;
  logic              bvalid_q;
  logic              rvalid_q;
  logic [DATA_W-1:0] rdata_q;
  logic [DATA_W-1:0] rd_word;
  arg_bank_t         args_q;

  assign wr_idx = axil_req_i.awaddr[5:2];
  assign rd_idx = axil_req_i.araddr[5:2];

  // Address and data are taken together, one write in flight.
  assign wr_fire = axil_req_i.awvalid & axil_req_i.wvalid & ~bvalid_q;
  assign rd_fire = axil_req_i.arvalid & ~rvalid_q;

  always_ff @(posedge user_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      bvalid_q <= 1'b0;
    end else if (wr_fire) begin
      bvalid_q <= 1'b1;
    end else if (axil_req_i.bready) begin
      bvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge user_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else if (rd_fire) begin
      rvalid_q <= 1'b1;
    end else if (axil_req_i.rready) begin
      rvalid_q <= 1'b0;
    end
  end

  // Argument bank, byte lanes follow wstrb.
  always_ff @(posedge user_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      args_q <= '0;
    end else if (wr_fire && (int'(wr_idx) < ARG_NUM)) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (axil_req_i.wstrb[b]) begin
          args_q[wr_idx[2:0]][b*8 +: 8] <= axil_req_i.wdata[b*8 +: 8];
        end
      end
    end
  end

  always_ff @(posedge user_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      kernel_cmd_o     <= 8'h00;
      kernel_cmd_new_o <= 1'b0;
      timer_start_o    <= 1'b0;
      timer_clear_o    <= 1'b0;
    end else begin
      kernel_cmd_new_o <= wr_fire && (wr_idx == 4'(REG_CMD));
      timer_start_o    <= wr_fire && (wr_idx == 4'(REG_CTRL)) && axil_req_i.wdata[0];
      timer_clear_o    <= wr_fire && (wr_idx == 4'(REG_CTRL)) && axil_req_i.wdata[1];
      if (wr_fire && (wr_idx == 4'(REG_CMD))) begin
        kernel_cmd_o <= axil_req_i.wdata[7:0];
      end
    end
  end

  // Status map seen by the host.
  always_comb begin
    case (rd_idx)
      4'd0:    rd_word = args_q[0];
      4'd1:    rd_word = state_i.state0;
      4'd2:    rd_word = state_i.state1;
      4'd3:    rd_word = state_i.state2;
      4'd4:    rd_word = state_i.state3;
      default: rd_word = '0;
    endcase
  end

  always_ff @(posedge user_clk) begin
    if (rd_fire) begin
      rdata_q <= rd_word;
    end
  end

  always_comb begin
    axil_rsp_o.awready = wr_fire;
    axil_rsp_o.wready  = wr_fire;
    axil_rsp_o.bresp   = RESP_OKAY;
    axil_rsp_o.bvalid  = bvalid_q;
    axil_rsp_o.arready = rd_fire;
    axil_rsp_o.rdata   = rdata_q;
    axil_rsp_o.rresp   = RESP_OKAY;
    axil_rsp_o.rvalid  = rvalid_q;
  end

  assign args_o = args_q;

endmodule

`default_nettype wire

// File: source/kernel_cmd_launcher.sv
`default_nettype none

module kernel_cmd_launcher (
  input  logic                user_clk,
  input  logic                rst_n_i,
  input  logic                kernel_cmd_new_i,
  input  host_pkg::arg_bank_t args_i,
  output host_pkg::cmd_port_t cmd_o
);
  import host_pkg::*;

  logic              pending_q;
  logic [DATA_W-1:0] count_q;
  logic              fire;
  logic              valid_q;
  logic [7:0]        cmd_byte_q;
  logic [DATA_W-1:0] data0_q;
  logic [DATA_W-1:0] data1_q;

  // A fresh command restarts the count and suppresses the old pulse.
  assign fire = pending_q & (count_q == '0) & ~kernel_cmd_new_i;

  always_ff @(posedge user_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pending_q <= 1'b0;
      count_q   <= '0;
      valid_q   <= 1'b0;
    end else begin
      valid_q <= fire;
      if (kernel_cmd_new_i) begin
        pending_q <= 1'b1;
        count_q   <= args_i[ARG_DELAY];
      end else if (pending_q) begin
        if (count_q == '0) begin
          pending_q <= 1'b0;
        end else begin
          count_q <= count_q - 1'b1;
        end
      end
    end
  end

  // Snapshot of the command words at load time.
  always_ff @(posedge user_clk) begin
    if (kernel_cmd_new_i) begin
      cmd_byte_q <= args_i[ARG_CMD][7:0];
      data0_q    <= args_i[ARG_DATA0];
      data1_q    <= args_i[ARG_DATA1];
    end
  end

  assign cmd_o = '{valid: valid_q, command: cmd_byte_q, data0: data0_q, data1: data1_q};

endmodule

`default_nettype wire
